// ==== include/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_DATA_W    8      // data and register width
`define CPU_ADDR_W    8      // memory address width

`define CPU_RESET_PC  8'h00  // first fetch address
`define CPU_DATA_BASE 8'hE0  // start of the 32-byte data region

`endif

// ==== verilog/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    // instruction byte is {type[1:0], srcdst, operand[4:0]}
    typedef enum logic [1:0] {
        OP_JUMP  = 2'b00,   // pc <= {srcdst, operand}
        OP_LOAD  = 2'b01,
        OP_STORE = 2'b10,
        OP_ADD   = 2'b11    // a + b mod 256
    } opcode_t;

    typedef enum logic {
        REG_A = 1'b0,
        REG_B = 1'b1
    } reg_sel_t;

endpackage

// ==== verilog/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

    // encoded as {en, ready}; 2'b01 is a stage draining after en fell
    typedef enum logic [1:0] {
        IDLE     = 2'b00,
        BUSY     = 2'b10,
        COMPLETE = 2'b11
    } stage_state_t;

    typedef enum logic {
        REQ_FETCH = 1'b0,
        REQ_EXEC  = 1'b1
    } requester_t;

endpackage

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module fetch_unit
    import cpu_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    input  logic [`CPU_ADDR_W-1:0] pc,
    input  logic [`CPU_DATA_W-1:0] data_in,
    input  logic                   mem_ready,
    output logic [`CPU_ADDR_W-1:0] addr,
    output logic                   mem_req,
    output logic [`CPU_DATA_W-1:0] inst,
    output logic                   ready
);

    stage_state_t state;

    assign state = stage_state_t'({en, ready});

    always_ff @(posedge clk) begin
        if (!rst) begin
            mem_req <= 1'b0;
            ready   <= 1'b0;
        end else if (state == BUSY) begin
            if (!mem_req) begin
                mem_req <= 1'b1;
            end else if (mem_ready) begin
                mem_req <= 1'b0;
                ready   <= 1'b1;
            end
        end else if (!en) begin
            mem_req <= 1'b0;   // drop a request that lost its enable
            ready   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == BUSY && !mem_req)
            addr <= pc;
        if (state == BUSY && mem_req && mem_ready)
            inst <= data_in;   // byte valid with mem_ready
    end

endmodule

// ==== verilog/decode_unit.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module decode_unit
    import cpu_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    input  logic [`CPU_DATA_W-1:0] inst,
    output opcode_t                op,
    output reg_sel_t               srcdst,
    output logic [5:0]             target,
    output logic                   ready
);

    always_ff @(posedge clk) begin
        if (!rst)
            ready <= 1'b0;
        else if (!en)
            ready <= 1'b0;
        else if (!ready)
            ready <= 1'b1;   // one cycle after en
    end

    always_ff @(posedge clk) begin
        if (en && !ready) begin
            op     <= opcode_t'(inst[7:6]);
            srcdst <= reg_sel_t'(inst[5]);
            target <= inst[5:0];   // jump field, low 5 bits are the operand
        end
    end

endmodule

// ==== verilog/execute_unit.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module execute_unit
    import cpu_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    input  opcode_t                op,
    input  logic [4:0]             operand,
    input  logic [`CPU_DATA_W-1:0] val1,
    input  logic [`CPU_DATA_W-1:0] val2,
    input  logic                   mem_ready,
    input  logic [`CPU_DATA_W-1:0] mem_data_in,
    output logic [`CPU_ADDR_W-1:0] mem_addr,
    output logic [`CPU_DATA_W-1:0] mem_data_out,
    output logic                   mem_req,
    output logic                   we,
    output logic [`CPU_DATA_W-1:0] result,
    output logic                   ready
);

    logic start;
    logic mem_done;
    logic is_mem_op;

    assign start     = en && !ready && !mem_req;
    assign mem_done  = en && mem_req && mem_ready;
    assign is_mem_op = (op == OP_LOAD) || (op == OP_STORE);

    always_ff @(posedge clk) begin
        if (!rst) begin
            mem_req <= 1'b0;
            we      <= 1'b0;
            ready   <= 1'b0;
        end else if (!en) begin
            mem_req <= 1'b0;
            we      <= 1'b0;
            ready   <= 1'b0;
        end else if (start) begin
            if (is_mem_op) begin
                mem_req <= 1'b1;
                we      <= (op == OP_STORE);
            end else begin
                ready   <= 1'b1;   // add finishes in one cycle
            end
        end else if (mem_done) begin
            mem_req <= 1'b0;
            we      <= 1'b0;
            ready   <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr     <= `CPU_DATA_BASE + `CPU_ADDR_W'(operand);
            mem_data_out <= val1;
            if (op == OP_ADD)
                result <= val1 + val2;
        end
        if (mem_done && op == OP_LOAD)
            result <= mem_data_in;
    end

endmodule

// ==== verilog/writeback_unit.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module writeback_unit
    import cpu_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    input  opcode_t                op,
    input  reg_sel_t               srcdst,
    input  logic [`CPU_DATA_W-1:0] val,
    output logic [`CPU_DATA_W-1:0] a,
    output logic [`CPU_DATA_W-1:0] b,
    output logic                   ready
);

    logic write;

    assign write = en && !ready && (op == OP_LOAD || op == OP_ADD);

    always_ff @(posedge clk) begin
        if (!rst) begin
            a     <= '0;
            b     <= '0;
            ready <= 1'b0;
        end else begin
            ready <= en;   // store completes without a write
            if (write && srcdst == REG_A)
                a <= val;
            if (write && srcdst == REG_B)
                b <= val;
        end
    end

endmodule

// ==== verilog/cpu_core.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_core
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CPU_DATA_W-1:0] data_in,
    input  logic                   mem_ready,
    output logic [`CPU_ADDR_W-1:0] addr,
    output logic [`CPU_DATA_W-1:0] data_out,
    output logic                   we,
    output logic                   mem_req
);

    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] reg_a, reg_b;
    requester_t             mem_owner;

    logic                   fetch_en, fetch_ready, fetch_mem_req, fetch_mem_ready;
    logic [`CPU_ADDR_W-1:0] fetch_addr;
    logic [`CPU_DATA_W-1:0] fetch_inst;

    logic                   dec_en, dec_ready;
    logic [`CPU_DATA_W-1:0] dec_inst;
    opcode_t                dec_op;
    reg_sel_t               dec_srcdst;
    logic [5:0]             dec_target;

    logic                   exec_en, exec_ready, exec_mem_req, exec_mem_ready, exec_we;
    opcode_t                exec_op;
    reg_sel_t               exec_srcdst;
    logic [4:0]             exec_operand;
    logic [`CPU_DATA_W-1:0] exec_val1, exec_val2, exec_data_out, exec_result;
    logic [`CPU_ADDR_W-1:0] exec_addr;

    logic                   wb_en, wb_ready;
    opcode_t                wb_op;
    reg_sel_t               wb_srcdst;

    stage_state_t fetch_state, dec_state, exec_state, wb_state;
    logic         fetch_quiet, fetch_start, fetch_to_dec, dec_issue, exec_to_wb;

    assign fetch_state = stage_state_t'({fetch_en, fetch_ready});
    assign dec_state   = stage_state_t'({dec_en, dec_ready});
    assign exec_state  = stage_state_t'({exec_en, exec_ready});
    assign wb_state    = stage_state_t'({wb_en, wb_ready});

    // a fetch dropped by a jump must finish on the port before the next one starts
    assign fetch_quiet  = !fetch_mem_req && !(mem_req && mem_owner == REQ_FETCH);
    assign fetch_start  = fetch_state == IDLE && exec_state != BUSY && fetch_quiet;
    assign fetch_to_dec = fetch_state == COMPLETE && dec_state == IDLE;
    assign dec_issue    = dec_state == COMPLETE && exec_state == IDLE && wb_state == IDLE;
    assign exec_to_wb   = exec_state == COMPLETE && wb_state == IDLE;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst), .en(fetch_en), .pc(pc),
        .data_in(data_in), .mem_ready(fetch_mem_ready),
        .addr(fetch_addr), .mem_req(fetch_mem_req),
        .inst(fetch_inst), .ready(fetch_ready)
    );

    decode_unit u_decode (
        .clk(clk), .rst(rst), .en(dec_en), .inst(dec_inst),
        .op(dec_op), .srcdst(dec_srcdst), .target(dec_target), .ready(dec_ready)
    );

    execute_unit u_execute (
        .clk(clk), .rst(rst), .en(exec_en), .op(exec_op), .operand(exec_operand),
        .val1(exec_val1), .val2(exec_val2),
        .mem_ready(exec_mem_ready), .mem_data_in(data_in),
        .mem_addr(exec_addr), .mem_data_out(exec_data_out),
        .mem_req(exec_mem_req), .we(exec_we),
        .result(exec_result), .ready(exec_ready)
    );

    writeback_unit u_writeback (
        .clk(clk), .rst(rst), .en(wb_en), .op(wb_op), .srcdst(wb_srcdst),
        .val(exec_result), .a(reg_a), .b(reg_b), .ready(wb_ready)
    );

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc       <= `CPU_RESET_PC;
            fetch_en <= 1'b0;
            dec_en   <= 1'b0;
            exec_en  <= 1'b0;
            wb_en    <= 1'b0;
        end else begin
            if (fetch_start)
                fetch_en <= 1'b1;
            if (fetch_to_dec) begin
                fetch_en <= 1'b0;
                dec_en   <= 1'b1;
                pc       <= pc + 1'b1;
            end
            if (dec_issue) begin
                dec_en <= 1'b0;
                if (dec_op == OP_JUMP) begin
                    pc       <= `CPU_ADDR_W'(dec_target);
                    fetch_en <= 1'b0;   // discard whatever was fetched
                end else begin
                    exec_en <= 1'b1;
                end
            end
            if (exec_to_wb) begin
                exec_en <= 1'b0;
                wb_en   <= 1'b1;
            end
            if (wb_state == COMPLETE)
                wb_en <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_to_dec)
            dec_inst <= fetch_inst;
        if (dec_issue) begin
            exec_op      <= dec_op;
            exec_operand <= dec_target[4:0];
            exec_srcdst  <= dec_srcdst;
            exec_val1    <= (dec_op == OP_STORE && dec_srcdst == REG_B) ? reg_b : reg_a;
            exec_val2    <= reg_b;
        end
        if (exec_to_wb) begin
            wb_op     <= exec_op;
            wb_srcdst <= exec_srcdst;
        end
    end

    // execute wins unless a fetch already holds the port
    assign fetch_mem_ready = mem_req && mem_owner == REQ_FETCH && mem_ready;
    assign exec_mem_ready  = mem_req && mem_owner == REQ_EXEC && mem_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            mem_req   <= 1'b0;
            we        <= 1'b0;
            mem_owner <= REQ_FETCH;
        end else if (mem_req) begin
            if (mem_ready) begin
                mem_req <= 1'b0;   // low for at least one cycle
                we      <= 1'b0;
            end
        end else if (exec_mem_req) begin
            mem_req   <= 1'b1;
            we        <= exec_we;
            mem_owner <= REQ_EXEC;
        end else if (fetch_mem_req) begin
            mem_req   <= 1'b1;
            we        <= 1'b0;
            mem_owner <= REQ_FETCH;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_req && exec_mem_req) begin
            addr     <= exec_addr;
            data_out <= exec_data_out;
        end else if (!mem_req && fetch_mem_req) begin
            addr     <= fetch_addr;
        end
    end

endmodule

// ==== testbench/cpu_asserts.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_asserts
    import cpu_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_req,
    input  logic                   mem_ready,
    input  logic                   we,
    input  logic [`CPU_ADDR_W-1:0] addr,
    input  logic [`CPU_DATA_W-1:0] data_out,
    input  requester_t             mem_owner
);

    int fail_count = 0;

    held_until_ready: assert property (@(posedge clk) disable iff (!rst)
        mem_req && !mem_ready |=> mem_req && $stable(addr) && $stable(we)
            && $stable(mem_owner))
        else begin
            fail_count++;
            $error("memory request dropped or changed before mem_ready");
        end

    // write data only matters while a write is pending
    write_data_held: assert property (@(posedge clk) disable iff (!rst)
        mem_req && we && !mem_ready |=> $stable(data_out))
        else begin
            fail_count++;
            $error("write data changed before mem_ready");
        end

    req_drops: assert property (@(posedge clk) disable iff (!rst)
        mem_req && mem_ready |=> !mem_req)
        else begin
            fail_count++;
            $error("mem_req stayed high after a completed access");
        end

    we_needs_req: assert property (@(posedge clk) disable iff (!rst)
        we |-> mem_req && mem_owner == REQ_EXEC)
        else begin
            fail_count++;
            $error("we high without an execute request");
        end

    write_in_data: assert property (@(posedge clk) disable iff (!rst)
        mem_req && we |-> addr >= `CPU_DATA_BASE)
        else begin
            fail_count++;
            $error("write outside the data region");
        end

endmodule

bind cpu_core cpu_asserts port_check (
    .clk(clk), .rst(rst), .mem_req(mem_req), .mem_ready(mem_ready), .we(we),
    .addr(addr), .data_out(data_out), .mem_owner(mem_owner)
);

// ==== testbench/cpu_checker.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_checker
    import cpu_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_req,
    input  logic                   mem_ready,
    input  logic                   we,
    input  logic [`CPU_ADDR_W-1:0] addr,
    input  logic [`CPU_DATA_W-1:0] data_out,
    input  logic [2047:0]          image,
    output logic                   expected_ready,
    output int                     exp_count,
    output int                     stores_seen,
    output int                     fetch_count,
    output int                     mismatch_count,
    output int                     extra_count
);

    logic [`CPU_ADDR_W-1:0] exp_addr [$];
    logic [`CPU_DATA_W-1:0] exp_data [$];
    logic                   rst_prev;
    logic                   first_req_seen;

    // runs the program on a copy of memory and collects the stores in order
    function automatic void build_expected(input logic [2047:0] img);
        logic [7:0] m [256];
        logic [7:0] pc;
        logic [7:0] next_pc;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] inst;
        logic [7:0] data_addr;
        int         steps;
        bit         halted;
        for (int i = 0; i < 256; i++)
            m[i] = img[i*8 +: 8];
        pc = `CPU_RESET_PC;
        a = '0;
        b = '0;
        steps = 0;
        halted = 1'b0;
        while (!halted && steps < 1000) begin
            inst      = m[pc];
            data_addr = `CPU_DATA_BASE + {3'b000, inst[4:0]};
            next_pc   = pc + 1;
            case (opcode_t'(inst[7:6]))
                OP_JUMP: begin
                    next_pc = {2'b00, inst[5:0]};
                    halted  = (next_pc == pc);   // jump to itself
                end
                OP_LOAD: begin
                    if (inst[5])
                        b = m[data_addr];
                    else
                        a = m[data_addr];
                end
                OP_STORE: begin
                    m[data_addr] = inst[5] ? b : a;
                    exp_addr.push_back(data_addr);
                    exp_data.push_back(m[data_addr]);
                end
                OP_ADD: begin
                    if (inst[5])
                        b = a + b;
                    else
                        a = a + b;
                end
            endcase
            pc = next_pc;
            steps++;
        end
    endfunction

    initial begin
        expected_ready = 1'b0;
        exp_count      = 0;
        stores_seen    = 0;
        fetch_count    = 0;
        mismatch_count = 0;
        extra_count    = 0;
        rst_prev       = 1'b0;
        first_req_seen = 1'b0;
    end

    always @(posedge clk) begin
        if (rst && !expected_ready) begin
            build_expected(image);
            exp_count      = exp_addr.size();
            expected_ready = 1'b1;
        end
        if (rst && !rst_prev && (mem_req !== 1'b0 || we !== 1'b0)) begin
            mismatch_count++;
            $display("Mismatch at %0t: mem_req=%b we=%b after reset, expected both low",
                     $time, mem_req, we);
        end
        if (rst && mem_req && !first_req_seen) begin
            first_req_seen = 1'b1;
            if (addr !== `CPU_RESET_PC || we !== 1'b0) begin
                mismatch_count++;
                $display("Mismatch at %0t: first request at %02h we=%b, expected read of %02h",
                         $time, addr, we, `CPU_RESET_PC);
            end
        end
        if (rst && mem_req && mem_ready && !we && addr < 64)
            fetch_count++;
        if (rst && mem_req && mem_ready && we) begin
            if (stores_seen < exp_count) begin
                if (addr !== exp_addr[stores_seen] || data_out !== exp_data[stores_seen]) begin
                    mismatch_count++;
                    $display("Mismatch at %0t: store %0d wrote %02h to %02h, expected %02h to %02h",
                             $time, stores_seen, data_out, addr,
                             exp_data[stores_seen], exp_addr[stores_seen]);
                end
            end else begin
                extra_count++;
                $display("Unexpected write of %02h to %02h after all expected stores",
                         data_out, addr);
            end
            stores_seen++;
        end
        rst_prev = rst;
    end

endmodule

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_tb;

    logic                   clk;
    logic                   rst;
    logic [`CPU_DATA_W-1:0] data_in;
    logic                   mem_ready;
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] data_out;
    logic                   we;
    logic                   mem_req;

    logic [`CPU_DATA_W-1:0] mem [256];
    logic [2047:0]          image;
    logic [15:0]            lfsr;
    logic                   pending;
    logic                   ack_done;
    logic                   in_reset;
    logic [7:0]             ack_wait;
    logic                   expected_ready;
    int                     exp_count;
    int                     stores_seen;
    int                     fetch_count;
    int                     mismatch_count;
    int                     extra_count;
    int                     timeout_count;
    int                     other_count;

    // copy/store, sums, forward jump over three instructions, then jump to itself
    localparam logic [7:0] program_bytes [16] = '{
        8'h40, 8'h90, 8'h61, 8'hB1,   // d0 -> d16, d1 -> d17
        8'hC0, 8'h92, 8'hE0, 8'hB3,   // a+b -> d18, a+b -> d19
        8'h0C, 8'h94, 8'h42, 8'hB5,   // jump 12 over the rest of this row
        8'h50, 8'hC0, 8'h96, 8'h0F    // reload d16, add, d22, halt
    };

    cpu_core DUT (
        .clk(clk), .rst(rst), .data_in(data_in), .mem_ready(mem_ready),
        .addr(addr), .data_out(data_out), .we(we), .mem_req(mem_req)
    );

    cpu_checker check (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_ready(mem_ready), .we(we),
        .addr(addr), .data_out(data_out), .image(image),
        .expected_ready(expected_ready), .exp_count(exp_count), .stores_seen(stores_seen),
        .fetch_count(fetch_count), .mismatch_count(mismatch_count),
        .extra_count(extra_count)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic random_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[6:0], lfsr[0]};
        end
    endtask

    task automatic fill_memory();
        logic [7:0] value;
        for (int i = 0; i < 256; i++)
            mem[i] = (i < 64) ? 8'(i) : 8'(i) ^ 8'hA5;   // program filler jumps to itself
        for (int i = 0; i < 16; i++)
            mem[i] = program_bytes[i];
        for (int i = 0; i < 32; i++) begin
            random_bits(8, value);
            mem[`CPU_DATA_BASE + i] = value;
        end
        for (int i = 0; i < 256; i++)
            image[i*8 +: 8] = mem[i];
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory model with 0 to 3 idle cycles before each acknowledge
    always @(posedge clk) begin
        ack_done = rst && mem_req && mem_ready;
        if (ack_done && we)
            mem[addr] = data_out;
        in_reset = !rst;
        #1;
        if (in_reset || ack_done) begin
            mem_ready = 1'b0;
            pending   = 1'b0;
        end else if (mem_req && !pending) begin
            pending = 1'b1;
            random_bits(2, ack_wait);
        end else if (pending && ack_wait != 0) begin
            ack_wait = ack_wait - 1;
        end
        if (pending && !mem_ready && ack_wait == 0) begin
            mem_ready = 1'b1;
            data_in   = mem[addr];
        end
    end

    task automatic wait_for_stores(input int limit);
        int cycles;
        cycles = 0;
        while (!(expected_ready && stores_seen >= exp_count) && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!(expected_ready && stores_seen >= exp_count)) begin
            timeout_count++;
            $display("Timeout after %0d cycles: only %0d of %0d expected stores appeared",
                     limit, stores_seen, exp_count);
        end
    endtask

    // after the halt fetches go on but nothing more is written
    task automatic observe_idle(input int window);
        int fetches_before;
        fetches_before = fetch_count;
        repeat (window) @(negedge clk);
        if (fetch_count == fetches_before) begin
            other_count++;
            $display("No fetch requests seen during the %0d-cycle idle window", window);
        end
    endtask

    task automatic print_summary();
        int assert_count;
        int total;
        assert_count = DUT.port_check.fail_count;
        total = mismatch_count + extra_count + timeout_count + other_count + assert_count;
        $display("errors: %0d mismatches, %0d extra writes, %0d timeouts, %0d other, %0d assertions",
                 mismatch_count, extra_count, timeout_count, other_count, assert_count);
        if (total == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    endtask

    initial begin
        rst           = 1'b0;
        mem_ready     = 1'b0;
        data_in       = '0;
        pending       = 1'b0;
        ack_wait      = '0;
        lfsr          = 16'd59233;
        timeout_count = 0;
        other_count   = 0;
        fill_memory();
        repeat (5) @(posedge clk);
        #1 rst = 1'b1;
        wait_for_stores(3000);
        observe_idle(200);
        print_summary();
    end

endmodule

// ==== project.f ====
+incdir+include
verilog/cpu_isa_pkg.sv
verilog/cpu_bus_pkg.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/writeback_unit.sv
verilog/cpu_core.sv
testbench/cpu_asserts.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv
